/* verilog/branch_pkg.sv */
//////////////////////////////////////////////////
// branch_pkg
// shared widths, instruction class flags and the
// packets passed between the three branch stages
//////////////////////////////////////////////////
package branch_pkg;

    typedef logic [31:0] word_t;     // data or address word
    typedef logic [4:0]  reg_idx_t;  // architectural register index
    typedef logic [19:0] imm_hi_t;   // instruction bits 31 to 12
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes handled by this path
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    // funct3 codes of the conditional branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;
    localparam funct3_t F3_JALR = 3'b000;

    // one-hot instruction class, all zero for anything unsupported
    typedef struct packed {
        logic beq;
        logic bge;
        logic bgeu;
        logic blt;
        logic bltu;
        logic bne;
        logic jalr;
        logic jal;
        logic auipc;
    } inst_flags_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       pc_next;    // pc plus 4, the link value
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        imm_hi_t     imm_1231;
        inst_flags_t flags;
    } decode_pkt_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       pc_next;
        reg_idx_t    rd;         // also holds the low B-immediate bits
        word_t       rs1_data;
        word_t       rs2_data;
        imm_hi_t     imm_1231;
        inst_flags_t flags;
    } operand_pkt_t;

    typedef struct packed {
        logic     valid;
        logic     jmp_en;     // redirect to pc_target
        logic     b_n_jmp;    // conditional branch that fell through
        word_t    pc_target;
        logic     rd_en;
        reg_idx_t rd;
        word_t    rd_data;
    } result_t;

endpackage

/* verilog/branch_decode.sv */
//////////////////////////////////////////////////
// branch_decode
// stage 1 of the branch path, classifies the
// instruction and registers its fields
//////////////////////////////////////////////////
`timescale 1ns/10ps

module branch_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst_valid,
    input  branch_pkg::word_t       inst,
    input  branch_pkg::word_t       pc,
    output branch_pkg::decode_pkt_t dec
);

    import branch_pkg::*;

    opcode_t     opcode;
    funct3_t     funct3;
    decode_pkt_t dec_d;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        dec_d          = '0;
        dec_d.valid    = inst_valid;
        dec_d.pc       = pc;
        dec_d.pc_next  = pc + 32'd4;
        dec_d.rd       = inst[11:7];
        dec_d.rs1      = inst[19:15];
        dec_d.rs2      = inst[24:20];
        dec_d.imm_1231 = inst[31:12];

        case (opcode)
            OP_BRANCH: begin
                case (funct3)
                    F3_BEQ:  dec_d.flags.beq  = 1'b1;
                    F3_BNE:  dec_d.flags.bne  = 1'b1;
                    F3_BLT:  dec_d.flags.blt  = 1'b1;
                    F3_BGE:  dec_d.flags.bge  = 1'b1;
                    F3_BLTU: dec_d.flags.bltu = 1'b1;
                    F3_BGEU: dec_d.flags.bgeu = 1'b1;
                    default: ;  // funct3 010 and 011 are not branches
                endcase
            end
            OP_JALR: begin
                if (funct3 == F3_JALR) begin
                    dec_d.flags.jalr = 1'b1;
                end
            end
            OP_JAL: begin
                dec_d.flags.jal = 1'b1;
            end
            OP_AUIPC: begin
                dec_d.flags.auipc = 1'b1;
            end
            default: ;  // unsupported opcode travels on with no flags
        endcase
    end

    // only the valid bit needs clearing, the payload follows the input
    always_ff @(posedge clk) begin
        dec <= dec_d;
        if (rst) begin
            dec.valid <= 1'b0;
        end
    end

endmodule

/* verilog/reg_file.sv */
//////////////////////////////////////////////////
// reg_file
// integer register file, two async reads and one
// write port, x0 and unbuilt registers read zero
//////////////////////////////////////////////////
`timescale 1ns/10ps

module reg_file #(
    parameter int REG_COUNT = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  branch_pkg::reg_idx_t rd_idx_a,
    input  branch_pkg::reg_idx_t rd_idx_b,
    output branch_pkg::word_t    rd_data_a,
    output branch_pkg::word_t    rd_data_b,
    input  logic                 wr_en,
    input  branch_pkg::reg_idx_t wr_idx,
    input  branch_pkg::word_t    wr_data
);

    import branch_pkg::*;

    localparam int IDX_W = $clog2(REG_COUNT);

    word_t regs [REG_COUNT];

    // true for an index that names a real, writable register
    function automatic logic idx_ok(input reg_idx_t idx);
        return (idx != '0) && (int'(idx) < REG_COUNT);
    endfunction

    assign rd_data_a = idx_ok(rd_idx_a) ? regs[rd_idx_a[IDX_W-1:0]] : '0;
    assign rd_data_b = idx_ok(rd_idx_b) ? regs[rd_idx_b[IDX_W-1:0]] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && idx_ok(wr_idx)) begin
            regs[wr_idx[IDX_W-1:0]] <= wr_data;  // x0 and RV32E upper half dropped
        end
    end

endmodule

/* verilog/branch_operands.sv */
//////////////////////////////////////////////////
// branch_operands
// stage 2, reads rs1 and rs2 with bypass from the
// two younger results and owns the writeback
//////////////////////////////////////////////////
`timescale 1ns/10ps

module branch_operands #(
    parameter int REG_COUNT = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  branch_pkg::decode_pkt_t  dec,
    input  branch_pkg::result_t      ex_next,
    input  branch_pkg::result_t      res,
    input  logic                     load_en,
    input  branch_pkg::reg_idx_t     load_idx,
    input  branch_pkg::word_t        load_data,
    output branch_pkg::operand_pkt_t opr
);

    import branch_pkg::*;

    logic         wb_en;
    logic         wr_en;
    reg_idx_t     wr_idx;
    word_t        wr_data;
    word_t        rf_rs1;
    word_t        rf_rs2;
    operand_pkt_t opr_d;

    // a result can feed a source only if it really writes that register
    function automatic logic writes_reg(input result_t r, input reg_idx_t idx);
        return r.valid && r.rd_en && (r.rd != '0) && (r.rd == idx);
    endfunction

    // nearest producer first, the register file last
    function automatic word_t pick_src(input reg_idx_t idx, input word_t rf_data,
                                       input result_t near, input result_t far);
        if (writes_reg(near, idx)) begin
            return near.rd_data;
        end
        if (writes_reg(far, idx)) begin
            return far.rd_data;
        end
        return rf_data;
    endfunction

    assign wb_en   = res.valid && res.rd_en;
    assign wr_en   = wb_en || load_en;
    assign wr_idx  = wb_en ? res.rd : load_idx;  // writeback beats a load
    assign wr_data = wb_en ? res.rd_data : load_data;

    reg_file #(
        .REG_COUNT (REG_COUNT)
    ) u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_a  (dec.rs1),
        .rd_idx_b  (dec.rs2),
        .rd_data_a (rf_rs1),
        .rd_data_b (rf_rs2),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    always_comb begin
        opr_d.valid    = dec.valid;
        opr_d.pc       = dec.pc;
        opr_d.pc_next  = dec.pc_next;
        opr_d.rd       = dec.rd;
        opr_d.rs1_data = pick_src(dec.rs1, rf_rs1, ex_next, res);
        opr_d.rs2_data = pick_src(dec.rs2, rf_rs2, ex_next, res);
        opr_d.imm_1231 = dec.imm_1231;
        opr_d.flags    = dec.flags;
    end

    always_ff @(posedge clk) begin
        opr <= opr_d;
        if (rst) begin
            opr.valid <= 1'b0;
        end
    end

endmodule

/* verilog/ex_branch.sv */
//////////////////////////////////////////////////
// ex_branch
// stage 3, branch compare, jump target and link or
// auipc value, registered into the result
//////////////////////////////////////////////////
`timescale 1ns/10ps

module ex_branch (
    input  logic                     clk,
    input  logic                     rst,
    input  branch_pkg::operand_pkt_t opr,
    output branch_pkg::result_t      ex_next,
    output branch_pkg::result_t      res
);

    import branch_pkg::*;

    inst_flags_t f;
    word_t       b_imm;
    word_t       j_imm;
    word_t       i_imm;
    word_t       u_imm;
    word_t       jalr_sum;
    logic        is_branch;
    logic        rs_eq;
    logic        rs_lt;
    logic        rs_ltu;
    logic        taken;

    assign f = opr.flags;

    // B-immediate takes bit 11 and bits 4:1 from the rd field
    assign b_imm = {{20{opr.imm_1231[19]}}, opr.rd[0], opr.imm_1231[18:13],
                    opr.rd[4:1], 1'b0};
    assign j_imm = {{12{opr.imm_1231[19]}}, opr.imm_1231[7:0], opr.imm_1231[8],
                    opr.imm_1231[18:9], 1'b0};
    assign i_imm = {{20{opr.imm_1231[19]}}, opr.imm_1231[19:8]};
    assign u_imm = {opr.imm_1231, 12'b0};

    assign jalr_sum = opr.rs1_data + i_imm;

    assign rs_eq  = (opr.rs1_data == opr.rs2_data);
    assign rs_lt  = ($signed(opr.rs1_data) < $signed(opr.rs2_data));
    assign rs_ltu = (opr.rs1_data < opr.rs2_data);

    assign is_branch = f.beq | f.bne | f.blt | f.bge | f.bltu | f.bgeu;

    // bge and bgeu are just the negated less-than results
    assign taken = (f.beq  &  rs_eq)  | (f.bne  & ~rs_eq)  |
                   (f.blt  &  rs_lt)  | (f.bge  & ~rs_lt)  |
                   (f.bltu &  rs_ltu) | (f.bgeu & ~rs_ltu);

    always_comb begin
        ex_next       = '0;
        ex_next.valid = opr.valid;
        if (opr.valid) begin
            if (is_branch) begin
                ex_next.pc_target = opr.pc + b_imm;
                ex_next.jmp_en    = taken;
                ex_next.b_n_jmp   = ~taken;
            end else if (f.jalr) begin
                ex_next.pc_target = {jalr_sum[31:1], 1'b0};  // target is always halfword aligned
                ex_next.jmp_en    = 1'b1;
                ex_next.rd_en     = 1'b1;
                ex_next.rd        = opr.rd;
                ex_next.rd_data   = opr.pc_next;
            end else if (f.jal) begin
                ex_next.pc_target = opr.pc + j_imm;
                ex_next.jmp_en    = 1'b1;
                ex_next.rd_en     = 1'b1;
                ex_next.rd        = opr.rd;
                ex_next.rd_data   = opr.pc_next;
            end else if (f.auipc) begin
                ex_next.rd_en   = 1'b1;
                ex_next.rd      = opr.rd;
                ex_next.rd_data = opr.pc + u_imm;
            end
            // anything else leaves a valid result with all enables low
        end
    end

    // the whole result clears on reset, consumers may look at any field
    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else begin
            res <= ex_next;
        end
    end

endmodule

/* verilog/branch_unit_top.sv */
//////////////////////////////////////////////////
// branch_unit_top
// three stage RV32I branch and jump path
//////////////////////////////////////////////////
`timescale 1ns/10ps

module branch_unit_top #(
    parameter int REG_COUNT = 32  // 16 builds the RV32E register file
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inst_valid,
    input  branch_pkg::word_t    inst,
    input  branch_pkg::word_t    pc,
    input  logic                 load_en,
    input  branch_pkg::reg_idx_t load_idx,
    input  branch_pkg::word_t    load_data,
    output branch_pkg::result_t  res
);

    import branch_pkg::*;

    decode_pkt_t  dec;
    operand_pkt_t opr;
    result_t      ex_next;  // stage 3 result before its register, for bypass

    branch_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .dec        (dec)
    );

    branch_operands #(
        .REG_COUNT (REG_COUNT)
    ) u_operands (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .ex_next   (ex_next),
        .res       (res),
        .load_en   (load_en),
        .load_idx  (load_idx),
        .load_data (load_data),
        .opr       (opr)
    );

    ex_branch u_ex_branch (
        .clk     (clk),
        .rst     (rst),
        .opr     (opr),
        .ex_next (ex_next),
        .res     (res)
    );

endmodule

/* sim/branch_unit_ref.svh */
//////////////////////////////////////////////////
// branch_unit_ref
// reference model of the branch path, worked out
// from the instruction word and in-order registers
//////////////////////////////////////////////////
`ifndef BRANCH_UNIT_REF_SVH
`define BRANCH_UNIT_REF_SVH

word_t shadow_regs [32];  // state with every issued instruction applied in order

function automatic word_t shadow_read(input reg_idx_t idx);
    return (idx == 5'd0) ? 32'd0 : shadow_regs[idx];
endfunction

function automatic void shadow_write(input reg_idx_t idx, input word_t val);
    if (idx != 5'd0) begin
        shadow_regs[idx] = val;
    end
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;  // bgeu, funct3 010 and 011 never get here
    endcase
endfunction

function automatic result_t expect_result(input word_t i, input word_t pc_now);
    result_t r;
    word_t   rs1_val;
    r       = '0;
    r.valid = 1'b1;
    rs1_val = shadow_read(i[19:15]);
    case (i[6:0])
        7'b1100011: begin
            if (i[14:13] != 2'b01) begin
                r.pc_target = pc_now + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
                r.jmp_en    = branch_taken(i[14:12], rs1_val, shadow_read(i[24:20]));
                r.b_n_jmp   = !r.jmp_en;
            end
        end
        7'b1101111, 7'b1100111: begin
            if (i[3] || i[14:12] == 3'b000) begin
                if (i[3]) begin  // jal, J-type offset
                    r.pc_target = pc_now + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
                end else begin
                    r.pc_target = (rs1_val + {{20{i[31]}}, i[31:20]}) & ~32'd1;
                end
                r.jmp_en  = 1'b1;
                r.rd_en   = 1'b1;
                r.rd      = i[11:7];
                r.rd_data = pc_now + 32'd4;
            end
        end
        7'b0010111: begin
            r.rd_en   = 1'b1;
            r.rd      = i[11:7];
            r.rd_data = pc_now + {i[31:12], 12'd0};
        end
        default: ;
    endcase
    return r;
endfunction

`endif

/* sim/branch_unit_tb.sv */
//////////////////////////////////////////////////
// branch_unit_tb
// runs short programs through the branch path and
// checks every result against the reference model
//////////////////////////////////////////////////
`timescale 1ns/10ps

module branch_unit_tb;

    import branch_pkg::*;

    `include "branch_unit_ref.svh"

    localparam int N_INSTR      = 95;  // all tests together
    localparam int LIMIT_CYCLES = 5 + 31 + N_INSTR + 6 * 8 + 20;
    localparam logic [2:0] BR_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    logic     clk = 1'b0;
    logic     rst;
    logic     inst_valid;
    word_t    inst;
    word_t    pc;
    logic     load_en;
    reg_idx_t load_idx;
    word_t    load_data;
    result_t  res;
    result_t  exp_q[$];
    int       due_q[$];  // edge count at which each result must sit in res
    int       edge_cnt = 0;
    int       err_cnt = 0;
    int       issued = 0;
    word_t    cur_pc;

    branch_unit_top #(.REG_COUNT(32)) UUT (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic word_t branch_word(input logic [2:0] f3, input reg_idx_t rs1,
                                          input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t jal_word(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t jalr_word(input reg_idx_t rd, input reg_idx_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic word_t auipc_word(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0010111};
    endfunction

    task automatic load_reg(input reg_idx_t idx, input word_t val);
        @(posedge clk);
        #10;
        load_en   = 1'b1;
        load_idx  = idx;
        load_data = val;
        shadow_write(idx, val);
    endtask

    task automatic issue(input word_t word);
        result_t want;
        @(posedge clk);
        #10;
        load_en    = 1'b0;
        inst_valid = 1'b1;
        inst       = word;
        pc         = cur_pc;
        want       = expect_result(word, cur_pc);  // operands before this write lands
        if (want.rd_en) begin
            shadow_write(want.rd, want.rd_data);
        end
        exp_q.push_back(want);
        due_q.push_back(edge_cnt + 3);  // sampled at the next edge, in res two edges later
        cur_pc = cur_pc + 32'd4;
        issued++;
    endtask

    task automatic end_test(input string name, input int first_err, input int count);
        @(posedge clk);
        #10;
        inst_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        $display("test %s: %0d instructions, %0d errors", name, count, err_cnt - first_err);
    endtask

    task automatic compare_field(input string name, input word_t got, input word_t want);
        assert (got == want) else begin
            $display("Fail at %0t: res.%s expected %h, got %h", $time, name, want, got);
            err_cnt++;
        end
    endtask

    // outputs are sampled on the falling edge, half a period after they change
    always @(negedge clk) begin : check_results
        result_t want;
        int      due;
        if (!rst && res.valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Result at %0t came with no instruction outstanding", $time);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                due  = due_q.pop_front();
                assert (edge_cnt == due) else begin
                    $display("Fail at %0t: res.valid edge expected %0d, got %0d",
                             $time, due, edge_cnt);
                    err_cnt++;
                end
                compare_field("jmp_en", word_t'(res.jmp_en), word_t'(want.jmp_en));
                compare_field("b_n_jmp", word_t'(res.b_n_jmp), word_t'(want.b_n_jmp));
                compare_field("pc_target", res.pc_target, want.pc_target);
                compare_field("rd_en", word_t'(res.rd_en), word_t'(want.rd_en));
                compare_field("rd", word_t'(res.rd), word_t'(want.rd));
                compare_field("rd_data", res.rd_data, want.rd_data);
            end
        end else if (!rst && due_q.size() != 0) begin
            assert (due_q[0] > edge_cnt) else begin
                $display("Result due at edge %0d never appeared, seen at %0t", due_q[0], $time);
                err_cnt++;
                want = exp_q.pop_front();
                due  = due_q.pop_front();
            end
        end
    end

    initial begin : stimulus
        int first_err;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        load_en    = 1'b0;
        load_idx   = '0;
        load_data  = '0;
        void'($urandom(43));
        cur_pc = $urandom() & 32'hffff_fffc;
        for (int r = 0; r < 32; r++) begin
            shadow_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;

        // x1 to x7 hold the compare corners, x6 and x7 are an equal pair
        load_reg(5'd1, 32'h0000_0000);
        load_reg(5'd2, 32'h0000_0001);
        load_reg(5'd3, 32'hffff_ffff);
        load_reg(5'd4, 32'h8000_0000);
        load_reg(5'd5, 32'h7fff_ffff);
        load_reg(5'd6, $urandom());
        load_reg(5'd7, shadow_read(5'd6));
        for (int r = 8; r < 32; r++) begin
            load_reg(5'(r), $urandom());
        end

        first_err = err_cnt;
        for (int n = 0; n < 48; n++) begin
            issue(branch_word(BR_F3[n % 6], 5'($urandom_range(9, 0)),
                              5'($urandom_range(9, 0)), 13'($urandom()) & 13'h1ffe));
        end
        end_test("branches", first_err, 48);

        first_err = err_cnt;
        for (int n = 0; n < 6; n++) begin
            issue(jal_word(5'($urandom_range(31, 8)), 21'($urandom()) & 21'h1ffffe));
        end
        end_test("jal", first_err, 6);

        first_err = err_cnt;
        for (int n = 0; n < 8; n++) begin
            issue(jalr_word(5'($urandom_range(31, 8)), 5'($urandom_range(31, 1)),
                            12'($urandom())));
        end
        end_test("jalr", first_err, 8);

        first_err = err_cnt;
        for (int n = 0; n < 6; n++) begin
            issue(auipc_word(5'($urandom_range(31, 8)), 20'($urandom())));
        end
        end_test("auipc", first_err, 6);

        first_err = err_cnt;
        for (int n = 0; n < 2; n++) begin
            issue(jal_word(5'd10, 21'h000100));
            issue(jalr_word(5'd11, 5'd10, 12'h005));  // x10 straight from stage 3
            issue(auipc_word(5'd12, 20'($urandom())));
            issue(branch_word(3'b100, 5'd12, 5'd11, 13'h0040));  // both bypass levels at once
            issue(jal_word(5'd13, 21'h1ffff0));
            issue(auipc_word(5'd20, 20'h00001));
            issue(jalr_word(5'd14, 5'd13, 12'hff3));  // x13 from the result register
            issue(auipc_word(5'd15, 20'($urandom())));
            issue(auipc_word(5'd21, 20'h00002));
            issue(branch_word(3'b111, 5'd15, 5'd14, 13'h1f00));
        end
        end_test("bypass", first_err, 20);

        first_err = err_cnt;
        issue(auipc_word(5'd0, 20'hfffff));
        issue(branch_word(3'b000, 5'd0, 5'd1, 13'h0010));  // taken only while x0 reads zero
        issue(jal_word(5'd0, 21'h000008));
        issue(jalr_word(5'd16, 5'd0, 12'h7ff));
        issue(32'h0020_8033);  // register add, not handled by this path
        issue(32'hffff_ffff);
        issue(32'h0000_2063);  // branch opcode with a reserved funct3
        end_test("x0 and unsupported", first_err, 7);

        $display("%0d instructions issued, %0d errors", issued, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(LIMIT_CYCLES * 100);
        $display("Run stopped after %0d cycles, results never drained", LIMIT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

/* branch_unit.f */
+incdir+sim
verilog/branch_pkg.sv
verilog/branch_decode.sv
verilog/reg_file.sv
verilog/branch_operands.sv
verilog/ex_branch.sv
verilog/branch_unit_top.sv
sim/branch_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the branch unit testbench with Verilator, run it and search the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f branch_unit.f \
    --top-module branch_unit_tb -o branch_unit_sim > build.log 2>&1 &&
./obj_dir/branch_unit_sim > sim.log 2>&1 &&
grep -qx "Everything OK" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
